// File: Bender.yml
package:
  name: axi_lite_subsys

sources:
  # Shared package first
  - common/axi_lite_pkg.sv
  # RTL
  - axi_lite_demux/axi_lite_demux.sv
  - design/axi_lite_regs.sv
  - design/axi_lite_perf_mon.sv
  - design/axi_lite_subsys.sv
  # Verification
  - target: test
    files:
      - verification/axi_lite_subsys_asserts.sv
      - verification/tb_axi_lite_subsys.sv

// File: axi_lite_demux/axi_lite_demux.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// AXI-Lite 1-to-N demultiplexer with address decode
// Unmatched addresses are answered here with DECERR
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

module axi_lite_demux #(
  parameter int unsigned NUM_SLAVE = 2
) (
  input  logic                                  clk_i,
  input  logic                                  rst_n_i,
  // Upstream port
  input  axi_lite_pkg::addr_t                   slv_aw_addr_i,
  input  logic                                  slv_aw_valid_i,
  output logic                                  slv_aw_ready_o,
  input  axi_lite_pkg::data_t                   slv_w_data_i,
  input  axi_lite_pkg::strb_t                   slv_w_strb_i,
  input  logic                                  slv_w_valid_i,
  output logic                                  slv_w_ready_o,
  output axi_lite_pkg::resp_t                   slv_b_resp_o,
  output logic                                  slv_b_valid_o,
  input  logic                                  slv_b_ready_i,
  input  axi_lite_pkg::addr_t                   slv_ar_addr_i,
  input  logic                                  slv_ar_valid_i,
  output logic                                  slv_ar_ready_o,
  output axi_lite_pkg::data_t                   slv_r_data_o,
  output axi_lite_pkg::resp_t                   slv_r_resp_o,
  output logic                                  slv_r_valid_o,
  input  logic                                  slv_r_ready_i,
  // Downstream ports, one per slave
  output axi_lite_pkg::addr_t [NUM_SLAVE-1:0]   mst_aw_addr_o,
  output logic                [NUM_SLAVE-1:0]   mst_aw_valid_o,
  input  logic                [NUM_SLAVE-1:0]   mst_aw_ready_i,
  output axi_lite_pkg::data_t [NUM_SLAVE-1:0]   mst_w_data_o,
  output axi_lite_pkg::strb_t [NUM_SLAVE-1:0]   mst_w_strb_o,
  output logic                [NUM_SLAVE-1:0]   mst_w_valid_o,
  input  logic                [NUM_SLAVE-1:0]   mst_w_ready_i,
  input  axi_lite_pkg::resp_t [NUM_SLAVE-1:0]   mst_b_resp_i,
  input  logic                [NUM_SLAVE-1:0]   mst_b_valid_i,
  output logic                [NUM_SLAVE-1:0]   mst_b_ready_o,
  output axi_lite_pkg::addr_t [NUM_SLAVE-1:0]   mst_ar_addr_o,
  output logic                [NUM_SLAVE-1:0]   mst_ar_valid_o,
  input  logic                [NUM_SLAVE-1:0]   mst_ar_ready_i,
  input  axi_lite_pkg::data_t [NUM_SLAVE-1:0]   mst_r_data_i,
  input  axi_lite_pkg::resp_t [NUM_SLAVE-1:0]   mst_r_resp_i,
  input  logic                [NUM_SLAVE-1:0]   mst_r_valid_i,
  output logic                [NUM_SLAVE-1:0]   mst_r_ready_o
);

  import axi_lite_pkg::*;

  typedef enum logic [2:0] {ST_IDLE, ST_FWD, ST_WAIT, ST_RESP, ST_ERR} fsm_state_t;

  // One-hot slave match, all zero on a miss
  function automatic logic [NUM_SLAVE-1:0] decode(input addr_t addr);
    logic [NUM_SLAVE-1:0] hit;
    hit = '0;
    for (int i = 0; i < NUM_SLAVE; i++) begin
      hit[i] = ((addr & RULE_MASK) == (RULE_STRIDE * addr_t'(i)));
    end
    return hit;
  endfunction

  fsm_state_t           w_state_q, r_state_q;
  logic [NUM_SLAVE-1:0] w_sel_q, r_sel_q;
  logic [NUM_SLAVE-1:0] aw_hit, ar_hit;
  logic                 aw_pend_q, w_pend_q;
  logic                 aw_done, w_done, ar_done;
  addr_t                aw_addr_q, ar_addr_q;
  data_t                w_data_q, r_data_q;
  strb_t                w_strb_q;
  resp_t                b_resp_q, r_resp_q;
  logic                 b_sel_valid, r_sel_valid;
  resp_t                b_sel_resp, r_sel_resp;
  data_t                r_sel_data;

  assign aw_hit = decode(slv_aw_addr_i);
  assign ar_hit = decode(slv_ar_addr_i);

  // Accept aw and w together, only in idle
  assign slv_aw_ready_o = (w_state_q == ST_IDLE) && slv_aw_valid_i && slv_w_valid_i;
  assign slv_w_ready_o  = slv_aw_ready_o;
  assign slv_ar_ready_o = (r_state_q == ST_IDLE) && slv_ar_valid_i;

  assign slv_b_valid_o = (w_state_q == ST_RESP) || (w_state_q == ST_ERR);
  assign slv_b_resp_o  = (w_state_q == ST_ERR) ? RESP_DECERR : b_resp_q;
  assign slv_r_valid_o = (r_state_q == ST_RESP) || (r_state_q == ST_ERR);
  assign slv_r_resp_o  = (r_state_q == ST_ERR) ? RESP_DECERR : r_resp_q;
  assign slv_r_data_o  = (r_state_q == ST_ERR) ? '0 : r_data_q;

  // Valids and readies only toward the selected slave
  assign mst_aw_valid_o = (w_state_q == ST_FWD && aw_pend_q) ? w_sel_q : '0;
  assign mst_w_valid_o  = (w_state_q == ST_FWD && w_pend_q) ? w_sel_q : '0;
  assign mst_b_ready_o  = (w_state_q == ST_WAIT) ? w_sel_q : '0;
  assign mst_ar_valid_o = (r_state_q == ST_FWD) ? r_sel_q : '0;
  assign mst_r_ready_o  = (r_state_q == ST_WAIT) ? r_sel_q : '0;

  assign aw_done = |(mst_aw_valid_o & mst_aw_ready_i);
  assign w_done  = |(mst_w_valid_o & mst_w_ready_i);
  assign ar_done = |(mst_ar_valid_o & mst_ar_ready_i);

  // Payload is shared, the valid picks the slave
  always_comb begin
    for (int i = 0; i < NUM_SLAVE; i++) begin
      mst_aw_addr_o[i] = aw_addr_q;
      mst_w_data_o[i]  = w_data_q;
      mst_w_strb_o[i]  = w_strb_q;
      mst_ar_addr_o[i] = ar_addr_q;
    end
  end

  // Response from the selected slave
  always_comb begin
    b_sel_valid = 1'b0;
    b_sel_resp  = RESP_OKAY;
    r_sel_valid = 1'b0;
    r_sel_resp  = RESP_OKAY;
    r_sel_data  = '0;
    for (int i = 0; i < NUM_SLAVE; i++) begin
      if (w_sel_q[i]) begin
        b_sel_valid = mst_b_valid_i[i];
        b_sel_resp  = mst_b_resp_i[i];
      end
      if (r_sel_q[i]) begin
        r_sel_valid = mst_r_valid_i[i];
        r_sel_resp  = mst_r_resp_i[i];
        r_sel_data  = mst_r_data_i[i];
      end
    end
  end

  // Write FSM
  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      w_state_q <= ST_IDLE;
      w_sel_q   <= '0;
      aw_pend_q <= 1'b0;
      w_pend_q  <= 1'b0;
    end else begin
      case (w_state_q)
        ST_IDLE: begin
          if (slv_aw_ready_o) begin
            w_sel_q <= aw_hit;
            if (|aw_hit) begin
              w_state_q <= ST_FWD;
              aw_pend_q <= 1'b1;
              w_pend_q  <= 1'b1;
            end else begin
              w_state_q <= ST_ERR;
            end
          end
        end
        ST_FWD: begin
          if (aw_done) aw_pend_q <= 1'b0;
          if (w_done) w_pend_q <= 1'b0;
          if ((!aw_pend_q || aw_done) && (!w_pend_q || w_done)) begin
            w_state_q <= ST_WAIT;
          end
        end
        ST_WAIT: if (b_sel_valid) w_state_q <= ST_RESP;
        ST_RESP, ST_ERR: if (slv_b_ready_i) w_state_q <= ST_IDLE;
        default: w_state_q <= ST_IDLE;
      endcase
    end
  end

  // Read FSM
  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      r_state_q <= ST_IDLE;
      r_sel_q   <= '0;
    end else begin
      case (r_state_q)
        ST_IDLE: begin
          if (slv_ar_ready_o) begin
            r_sel_q   <= ar_hit;
            r_state_q <= (|ar_hit) ? ST_FWD : ST_ERR;
          end
        end
        ST_FWD: if (ar_done) r_state_q <= ST_WAIT;
        ST_WAIT: if (r_sel_valid) r_state_q <= ST_RESP;
        ST_RESP, ST_ERR: if (slv_r_ready_i) r_state_q <= ST_IDLE;
        default: r_state_q <= ST_IDLE;
      endcase
    end
  end

  // Request and response payload capture
  always_ff @(posedge clk_i) begin
    if (slv_aw_ready_o) begin
      aw_addr_q <= slv_aw_addr_i;
      w_data_q  <= slv_w_data_i;
      w_strb_q  <= slv_w_strb_i;
    end
    if (w_state_q == ST_WAIT && b_sel_valid) begin
      b_resp_q <= b_sel_resp;
    end
    if (slv_ar_ready_o) begin
      ar_addr_q <= slv_ar_addr_i;
    end
    if (r_state_q == ST_WAIT && r_sel_valid) begin
      r_data_q <= r_sel_data;
      r_resp_q <= r_sel_resp;
    end
  end

endmodule

// File: common/axi_lite_pkg.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Shared AXI-Lite widths, response codes and address rule
// Imported by every block of the peripheral subsystem
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

package axi_lite_pkg;

  // Bus widths
  localparam int unsigned ADDR_WIDTH = 32;
  localparam int unsigned DATA_WIDTH = 32;
  localparam int unsigned STRB_WIDTH = DATA_WIDTH / 8;

  typedef logic [ADDR_WIDTH-1:0] addr_t;
  typedef logic [DATA_WIDTH-1:0] data_t;
  typedef logic [STRB_WIDTH-1:0] strb_t;

  // AXI response encoding
  typedef enum logic [1:0] {
    RESP_OKAY   = 2'b00,
    RESP_EXOKAY = 2'b01,
    RESP_SLVERR = 2'b10,
    RESP_DECERR = 2'b11
  } resp_t;

  // Address rule, slave i answers where (addr & RULE_MASK) == i * RULE_STRIDE
  localparam addr_t RULE_MASK   = 32'hfffff000;
  localparam addr_t RULE_STRIDE = 32'h00010000;

  // Words per register block, selected by address bits 3:2
  localparam int unsigned REG_WORDS = 4;

endpackage

// File: design/axi_lite_perf_mon.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Saturating write, read and error counters
// Observes the b and r channels of one AXI-Lite port
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

module axi_lite_perf_mon #(
  parameter int unsigned CNT_WIDTH = 16
) (
  input  logic                 clk_i,
  input  logic                 rst_n_i,
  input  logic                 b_valid_i,
  input  logic                 b_ready_i,
  input  axi_lite_pkg::resp_t  b_resp_i,
  input  logic                 r_valid_i,
  input  logic                 r_ready_i,
  input  axi_lite_pkg::resp_t  r_resp_i,
  output logic [CNT_WIDTH-1:0] wr_count_o,
  output logic [CNT_WIDTH-1:0] rd_count_o,
  output logic [CNT_WIDTH-1:0] err_count_o
);

  import axi_lite_pkg::*;

  logic                 b_fire, r_fire;
  logic                 b_err, r_err;
  logic [1:0]           err_inc;
  logic [CNT_WIDTH:0]   err_sum;
  logic [CNT_WIDTH-1:0] wr_cnt_q, rd_cnt_q, err_cnt_q;

  assign b_fire = b_valid_i && b_ready_i;
  assign r_fire = r_valid_i && r_ready_i;
  assign b_err  = b_fire && (b_resp_i != RESP_OKAY);
  assign r_err  = r_fire && (r_resp_i != RESP_OKAY);

  // Up to two errors per cycle, one extra bit catches the overflow
  assign err_inc = {1'b0, b_err} + {1'b0, r_err};
  assign err_sum = {1'b0, err_cnt_q} + {{(CNT_WIDTH-1){1'b0}}, err_inc};

  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      wr_cnt_q  <= '0;
      rd_cnt_q  <= '0;
      err_cnt_q <= '0;
    end else begin
      if (b_fire && (wr_cnt_q != '1)) wr_cnt_q <= wr_cnt_q + 1'b1;
      if (r_fire && (rd_cnt_q != '1)) rd_cnt_q <= rd_cnt_q + 1'b1;
      err_cnt_q <= err_sum[CNT_WIDTH] ? '1 : err_sum[CNT_WIDTH-1:0];
    end
  end

  assign wr_count_o  = wr_cnt_q;
  assign rd_count_o  = rd_cnt_q;
  assign err_count_o = err_cnt_q;

endmodule

// File: design/axi_lite_regs.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// AXI-Lite register block, four words with byte strobes
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

module axi_lite_regs (
  input  logic                clk_i,
  input  logic                rst_n_i,
  input  axi_lite_pkg::addr_t aw_addr_i,
  input  logic                aw_valid_i,
  output logic                aw_ready_o,
  input  axi_lite_pkg::data_t w_data_i,
  input  axi_lite_pkg::strb_t w_strb_i,
  input  logic                w_valid_i,
  output logic                w_ready_o,
  output axi_lite_pkg::resp_t b_resp_o,
  output logic                b_valid_o,
  input  logic                b_ready_i,
  input  axi_lite_pkg::addr_t ar_addr_i,
  input  logic                ar_valid_i,
  output logic                ar_ready_o,
  output axi_lite_pkg::data_t r_data_o,
  output axi_lite_pkg::resp_t r_resp_o,
  output logic                r_valid_o,
  input  logic                r_ready_i
);

  import axi_lite_pkg::*;

  localparam int unsigned IDX_WIDTH = $clog2(REG_WORDS);

  data_t                mem_q [REG_WORDS];
  logic                 b_valid_q, r_valid_q;
  data_t                r_data_q;
  logic                 wr_fire, rd_fire;
  logic [IDX_WIDTH-1:0] wr_idx, rd_idx;

  // Word select from bits 3:2, higher offset bits alias
  assign wr_idx = aw_addr_i[IDX_WIDTH+1:2];
  assign rd_idx = ar_addr_i[IDX_WIDTH+1:2];

  // aw and w are taken in the same cycle
  assign wr_fire    = aw_valid_i && w_valid_i && !b_valid_q;
  assign aw_ready_o = wr_fire;
  assign w_ready_o  = wr_fire;

  assign rd_fire    = ar_valid_i && !r_valid_q;
  assign ar_ready_o = rd_fire;

  assign b_valid_o = b_valid_q;
  assign b_resp_o  = RESP_OKAY;
  assign r_valid_o = r_valid_q;
  assign r_data_o  = r_data_q;
  assign r_resp_o  = RESP_OKAY;

  // Storage with per-byte write enable
  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      for (int i = 0; i < REG_WORDS; i++) begin
        mem_q[i] <= '0;
      end
    end else if (wr_fire) begin
      for (int b = 0; b < STRB_WIDTH; b++) begin
        if (w_strb_i[b]) mem_q[wr_idx][8*b +: 8] <= w_data_i[8*b +: 8];
      end
    end
  end

  // Response handshake state
  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      b_valid_q <= 1'b0;
      r_valid_q <= 1'b0;
    end else begin
      if (wr_fire) begin
        b_valid_q <= 1'b1;
      end else if (b_ready_i) begin
        b_valid_q <= 1'b0;
      end
      if (rd_fire) begin
        r_valid_q <= 1'b1;
      end else if (r_ready_i) begin
        r_valid_q <= 1'b0;
      end
    end
  end

  // Read data held until the r transfer
  always_ff @(posedge clk_i) begin
    if (rd_fire) r_data_q <= mem_q[rd_idx];
  end

endmodule

// File: design/axi_lite_subsys.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// AXI-Lite peripheral subsystem top level
// Demux, NUM_SLAVE register blocks and a port monitor
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

module axi_lite_subsys #(
  parameter int unsigned NUM_SLAVE = 2,
  parameter int unsigned CNT_WIDTH = 16
) (
  input  logic                 clk_i,
  input  logic                 rst_n_i,
  input  axi_lite_pkg::addr_t  aw_addr_i,
  input  logic                 aw_valid_i,
  output logic                 aw_ready_o,
  input  axi_lite_pkg::data_t  w_data_i,
  input  axi_lite_pkg::strb_t  w_strb_i,
  input  logic                 w_valid_i,
  output logic                 w_ready_o,
  output axi_lite_pkg::resp_t  b_resp_o,
  output logic                 b_valid_o,
  input  logic                 b_ready_i,
  input  axi_lite_pkg::addr_t  ar_addr_i,
  input  logic                 ar_valid_i,
  output logic                 ar_ready_o,
  output axi_lite_pkg::data_t  r_data_o,
  output axi_lite_pkg::resp_t  r_resp_o,
  output logic                 r_valid_o,
  input  logic                 r_ready_i,
  output logic [CNT_WIDTH-1:0] wr_count_o,
  output logic [CNT_WIDTH-1:0] rd_count_o,
  output logic [CNT_WIDTH-1:0] err_count_o
);

  import axi_lite_pkg::*;

  // Demux to register block wiring
  addr_t [NUM_SLAVE-1:0] mst_aw_addr, mst_ar_addr;
  data_t [NUM_SLAVE-1:0] mst_w_data, mst_r_data;
  strb_t [NUM_SLAVE-1:0] mst_w_strb;
  resp_t [NUM_SLAVE-1:0] mst_b_resp, mst_r_resp;
  logic  [NUM_SLAVE-1:0] mst_aw_valid, mst_aw_ready, mst_w_valid, mst_w_ready;
  logic  [NUM_SLAVE-1:0] mst_b_valid, mst_b_ready, mst_ar_valid, mst_ar_ready;
  logic  [NUM_SLAVE-1:0] mst_r_valid, mst_r_ready;

  axi_lite_demux #(
    .NUM_SLAVE (NUM_SLAVE)
  ) i_demux (
    .clk_i          (clk_i),
    .rst_n_i        (rst_n_i),
    .slv_aw_addr_i  (aw_addr_i),
    .slv_aw_valid_i (aw_valid_i),
    .slv_aw_ready_o (aw_ready_o),
    .slv_w_data_i   (w_data_i),
    .slv_w_strb_i   (w_strb_i),
    .slv_w_valid_i  (w_valid_i),
    .slv_w_ready_o  (w_ready_o),
    .slv_b_resp_o   (b_resp_o),
    .slv_b_valid_o  (b_valid_o),
    .slv_b_ready_i  (b_ready_i),
    .slv_ar_addr_i  (ar_addr_i),
    .slv_ar_valid_i (ar_valid_i),
    .slv_ar_ready_o (ar_ready_o),
    .slv_r_data_o   (r_data_o),
    .slv_r_resp_o   (r_resp_o),
    .slv_r_valid_o  (r_valid_o),
    .slv_r_ready_i  (r_ready_i),
    .mst_aw_addr_o  (mst_aw_addr),
    .mst_aw_valid_o (mst_aw_valid),
    .mst_aw_ready_i (mst_aw_ready),
    .mst_w_data_o   (mst_w_data),
    .mst_w_strb_o   (mst_w_strb),
    .mst_w_valid_o  (mst_w_valid),
    .mst_w_ready_i  (mst_w_ready),
    .mst_b_resp_i   (mst_b_resp),
    .mst_b_valid_i  (mst_b_valid),
    .mst_b_ready_o  (mst_b_ready),
    .mst_ar_addr_o  (mst_ar_addr),
    .mst_ar_valid_o (mst_ar_valid),
    .mst_ar_ready_i (mst_ar_ready),
    .mst_r_data_i   (mst_r_data),
    .mst_r_resp_i   (mst_r_resp),
    .mst_r_valid_i  (mst_r_valid),
    .mst_r_ready_o  (mst_r_ready)
  );

  for (genvar i = 0; i < NUM_SLAVE; i++) begin : gen_regs
    axi_lite_regs i_regs (
      .clk_i      (clk_i),
      .rst_n_i    (rst_n_i),
      .aw_addr_i  (mst_aw_addr[i]),
      .aw_valid_i (mst_aw_valid[i]),
      .aw_ready_o (mst_aw_ready[i]),
      .w_data_i   (mst_w_data[i]),
      .w_strb_i   (mst_w_strb[i]),
      .w_valid_i  (mst_w_valid[i]),
      .w_ready_o  (mst_w_ready[i]),
      .b_resp_o   (mst_b_resp[i]),
      .b_valid_o  (mst_b_valid[i]),
      .b_ready_i  (mst_b_ready[i]),
      .ar_addr_i  (mst_ar_addr[i]),
      .ar_valid_i (mst_ar_valid[i]),
      .ar_ready_o (mst_ar_ready[i]),
      .r_data_o   (mst_r_data[i]),
      .r_resp_o   (mst_r_resp[i]),
      .r_valid_o  (mst_r_valid[i]),
      .r_ready_i  (mst_r_ready[i])
    );
  end

  // Monitor taps the upstream response channels
  axi_lite_perf_mon #(
    .CNT_WIDTH (CNT_WIDTH)
  ) i_perf_mon (
    .clk_i       (clk_i),
    .rst_n_i     (rst_n_i),
    .b_valid_i   (b_valid_o),
    .b_ready_i   (b_ready_i),
    .b_resp_i    (b_resp_o),
    .r_valid_i   (r_valid_o),
    .r_ready_i   (r_ready_i),
    .r_resp_i    (r_resp_o),
    .wr_count_o  (wr_count_o),
    .rd_count_o  (rd_count_o),
    .err_count_o (err_count_o)
  );

endmodule

// File: tb.f
common/axi_lite_pkg.sv
axi_lite_demux/axi_lite_demux.sv
design/axi_lite_regs.sv
design/axi_lite_perf_mon.sv
design/axi_lite_subsys.sv
verification/axi_lite_subsys_asserts.sv
verification/tb_axi_lite_subsys.sv

// File: verification/axi_lite_subsys_asserts.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Handshake checks on the subsystem upstream port
// Bound into every axi_lite_subsys instance
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

module axi_lite_subsys_asserts (
  input logic                clk_i,
  input logic                rst_n_i,
  input axi_lite_pkg::resp_t b_resp_i,
  input logic                b_valid_i,
  input logic                b_ready_i,
  input axi_lite_pkg::data_t r_data_i,
  input axi_lite_pkg::resp_t r_resp_i,
  input logic                r_valid_i,
  input logic                r_ready_i
);

  import axi_lite_pkg::*;

  // Responses hold under back-pressure
  b_stable: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    b_valid_i && !b_ready_i |=> b_valid_i && $stable(b_resp_i))
    else $error("b response dropped or changed before b ready");

  r_stable: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    r_valid_i && !r_ready_i |=> r_valid_i && $stable(r_data_i) && $stable(r_resp_i))
    else $error("r response dropped or changed before r ready");

  quiet_after_reset: assert property (@(posedge clk_i)
    !rst_n_i |=> !b_valid_i && !r_valid_i)
    else $error("response valid high in the cycle after reset");

  // EXOKAY has no meaning without exclusive access
  no_exokay: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    b_valid_i |-> b_resp_i != RESP_EXOKAY)
    else $error("b response carries EXOKAY");

endmodule

bind axi_lite_subsys axi_lite_subsys_asserts i_asserts (
  .clk_i     (clk_i),
  .rst_n_i   (rst_n_i),
  .b_resp_i  (b_resp_o),
  .b_valid_i (b_valid_o),
  .b_ready_i (b_ready_i),
  .r_data_i  (r_data_o),
  .r_resp_i  (r_resp_o),
  .r_valid_i (r_valid_o),
  .r_ready_i (r_ready_i)
);

// File: verification/tb_axi_lite_subsys.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Table-driven testbench for the AXI-Lite subsystem
// Expected values come from a register model in the bench
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

module tb_axi_lite_subsys;

  import axi_lite_pkg::*;

  localparam int unsigned NUM_SLAVE  = 2;
  localparam int unsigned CNT_WIDTH  = 16;
  localparam int          CLK_PERIOD = 20;
  localparam int          DRIVE_DLY  = 2;
  localparam int          TIMEOUT    = 50;
  localparam int          TBL_MAX    = 16;

  logic                 clk_i;
  logic                 rst_n_i;
  addr_t                aw_addr_i;
  logic                 aw_valid_i;
  logic                 aw_ready_o;
  data_t                w_data_i;
  strb_t                w_strb_i;
  logic                 w_valid_i;
  logic                 w_ready_o;
  resp_t                b_resp_o;
  logic                 b_valid_o;
  logic                 b_ready_i;
  addr_t                ar_addr_i;
  logic                 ar_valid_i;
  logic                 ar_ready_o;
  data_t                r_data_o;
  resp_t                r_resp_o;
  logic                 r_valid_o;
  logic                 r_ready_i;
  logic [CNT_WIDTH-1:0] wr_count_o;
  logic [CNT_WIDTH-1:0] rd_count_o;
  logic [CNT_WIDTH-1:0] err_count_o;

  // Stimulus table, one entry per transaction
  string tbl_name     [TBL_MAX];
  logic  tbl_is_wr    [TBL_MAX];
  addr_t tbl_addr     [TBL_MAX];
  data_t tbl_data     [TBL_MAX];
  strb_t tbl_strb     [TBL_MAX];
  data_t tbl_exp_data [TBL_MAX];
  resp_t tbl_exp_resp [TBL_MAX];
  int    tbl_len;

  // Register model of every slave
  data_t model_mem [NUM_SLAVE][REG_WORDS];

  int error_count;
  int test_count;
  int test_fail;
  bit timed_out;

  axi_lite_subsys #(
    .NUM_SLAVE (NUM_SLAVE),
    .CNT_WIDTH (CNT_WIDTH)
  ) UUT (
    .clk_i       (clk_i),
    .rst_n_i     (rst_n_i),
    .aw_addr_i   (aw_addr_i),
    .aw_valid_i  (aw_valid_i),
    .aw_ready_o  (aw_ready_o),
    .w_data_i    (w_data_i),
    .w_strb_i    (w_strb_i),
    .w_valid_i   (w_valid_i),
    .w_ready_o   (w_ready_o),
    .b_resp_o    (b_resp_o),
    .b_valid_o   (b_valid_o),
    .b_ready_i   (b_ready_i),
    .ar_addr_i   (ar_addr_i),
    .ar_valid_i  (ar_valid_i),
    .ar_ready_o  (ar_ready_o),
    .r_data_o    (r_data_o),
    .r_resp_o    (r_resp_o),
    .r_valid_o   (r_valid_o),
    .r_ready_i   (r_ready_i),
    .wr_count_o  (wr_count_o),
    .rd_count_o  (rd_count_o),
    .err_count_o (err_count_o)
  );

  initial begin
    clk_i = 1'b0;
    forever #(CLK_PERIOD / 2) clk_i = ~clk_i;
  end

  // Slave index whose window holds the address, -1 for none
  function automatic int slave_of(input addr_t addr);
    for (int i = 0; i < NUM_SLAVE; i++) begin
      if ((addr & RULE_MASK) == addr_t'(i) * RULE_STRIDE) return i;
    end
    return -1;
  endfunction

  task automatic add_write(input string name, input addr_t addr, input data_t data,
                           input strb_t strb);
    int slv;
    slv = slave_of(addr);
    tbl_name[tbl_len]     = name;
    tbl_is_wr[tbl_len]    = 1'b1;
    tbl_addr[tbl_len]     = addr;
    tbl_data[tbl_len]     = data;
    tbl_strb[tbl_len]     = strb;
    tbl_exp_data[tbl_len] = '0;
    tbl_exp_resp[tbl_len] = (slv < 0) ? RESP_DECERR : RESP_OKAY;
    if (slv >= 0) begin
      for (int b = 0; b < STRB_WIDTH; b++) begin
        if (strb[b]) model_mem[slv][addr[3:2]][8*b +: 8] = data[8*b +: 8];
      end
    end
    tbl_len++;
  endtask

  task automatic add_read(input string name, input addr_t addr);
    int slv;
    slv = slave_of(addr);
    tbl_name[tbl_len]     = name;
    tbl_is_wr[tbl_len]    = 1'b0;
    tbl_addr[tbl_len]     = addr;
    tbl_data[tbl_len]     = '0;
    tbl_strb[tbl_len]     = '0;
    tbl_exp_data[tbl_len] = (slv < 0) ? '0 : model_mem[slv][addr[3:2]];
    tbl_exp_resp[tbl_len] = (slv < 0) ? RESP_DECERR : RESP_OKAY;
    tbl_len++;
  endtask

  task automatic build_table();
    tbl_len = 0;
    for (int s = 0; s < NUM_SLAVE; s++) begin
      for (int w = 0; w < REG_WORDS; w++) model_mem[s][w] = '0;
    end
    add_write("wr_s0_word1", 32'h00000004, 32'h11223344, 4'b1111);
    add_write("wr_s1_word2", 32'h00010008, 32'ha5a55a5a, 4'b1111);
    add_read("rd_s0_word1", 32'h00000004);
    add_read("rd_s1_word2", 32'h00010008);
    add_read("rd_s0_word2", 32'h00000008);
    add_write("wr_strb_0101", 32'h00000004, 32'hdeadbeef, 4'b0101);
    add_read("rd_alias_word1", 32'h00000014);
    add_write("wr_unmapped", 32'h00020000, 32'hffffffff, 4'b1111);
    add_read("rd_unmapped", 32'h00020000);
    add_read("rd_s0_word0", 32'h00000000);
    add_read("rd_s1_word0", 32'h00010000);
    add_write("wr_s1_alias3", 32'h00010ffc, 32'h0badf00d, 4'b1100);
    add_read("rd_s1_word3", 32'h0001000c);
  endtask

  task automatic check_data(input string name, input data_t exp, input data_t act);
    if (exp !== act) begin
      $display("MISMATCH %s: expected data %08h, actual %08h", name, exp, act);
      error_count++;
    end
  endtask

  task automatic check_resp(input string name, input resp_t exp, input resp_t act);
    if (exp !== act) begin
      $display("MISMATCH %s: expected resp %0d, actual %0d", name, exp, act);
      error_count++;
    end
  endtask

  task automatic check_count(input string name, input logic [CNT_WIDTH-1:0] exp,
                             input logic [CNT_WIDTH-1:0] act);
    if (exp !== act) begin
      $display("MISMATCH %s: expected count %0d, actual %0d", name, exp, act);
      error_count++;
    end
  endtask

  task automatic check_flag(input string name, input logic exp, input logic act);
    if (exp !== act) begin
      $display("MISMATCH %s: expected flag %b, actual %b", name, exp, act);
      error_count++;
    end
  endtask

  task automatic report_timeout(input string name, input string what);
    $display("Test %s timed out after %0d cycles waiting for %s", name, TIMEOUT, what);
    error_count++;
    timed_out = 1'b1;
  endtask

  task automatic close_test(input string name, input int errs_before);
    test_count++;
    if (error_count == errs_before) begin
      $display("PASS %s", name);
    end else begin
      test_fail++;
      $display("FAIL %s", name);
    end
  endtask

  // Called at the drive point after a rising edge, returns at the same point
  task automatic run_write(input int idx, output resp_t resp);
    int cycles;
    int delay;
    resp       = RESP_OKAY;
    aw_addr_i  = tbl_addr[idx];
    w_data_i   = tbl_data[idx];
    w_strb_i   = tbl_strb[idx];
    aw_valid_i = 1'b1;
    w_valid_i  = 1'b1;
    cycles     = 0;
    @(negedge clk_i);
    while (!aw_ready_o && cycles < TIMEOUT) begin
      @(negedge clk_i);
      cycles++;
    end
    if (!aw_ready_o) begin
      report_timeout(tbl_name[idx], "aw ready");
      return;
    end
    // w is accepted in the same cycle as aw
    check_flag(tbl_name[idx], 1'b1, w_ready_o);
    @(posedge clk_i);
    #DRIVE_DLY;
    aw_valid_i = 1'b0;
    w_valid_i  = 1'b0;
    // Hold off b ready to exercise back-pressure
    delay = $urandom_range(3, 0);
    repeat (delay) begin
      @(posedge clk_i);
      #DRIVE_DLY;
    end
    b_ready_i = 1'b1;
    cycles    = 0;
    @(negedge clk_i);
    while (!b_valid_o && cycles < TIMEOUT) begin
      @(negedge clk_i);
      cycles++;
    end
    if (!b_valid_o) begin
      report_timeout(tbl_name[idx], "b valid");
      return;
    end
    resp = b_resp_o;
    @(posedge clk_i);
    #DRIVE_DLY;
    b_ready_i = 1'b0;
  endtask

  task automatic run_read(input int idx, output data_t data, output resp_t resp);
    int cycles;
    int delay;
    data       = '0;
    resp       = RESP_OKAY;
    ar_addr_i  = tbl_addr[idx];
    ar_valid_i = 1'b1;
    cycles     = 0;
    @(negedge clk_i);
    while (!ar_ready_o && cycles < TIMEOUT) begin
      @(negedge clk_i);
      cycles++;
    end
    if (!ar_ready_o) begin
      report_timeout(tbl_name[idx], "ar ready");
      return;
    end
    @(posedge clk_i);
    #DRIVE_DLY;
    ar_valid_i = 1'b0;
    delay = $urandom_range(3, 0);
    repeat (delay) begin
      @(posedge clk_i);
      #DRIVE_DLY;
    end
    r_ready_i = 1'b1;
    cycles    = 0;
    @(negedge clk_i);
    while (!r_valid_o && cycles < TIMEOUT) begin
      @(negedge clk_i);
      cycles++;
    end
    if (!r_valid_o) begin
      report_timeout(tbl_name[idx], "r valid");
      return;
    end
    data = r_data_o;
    resp = r_resp_o;
    @(posedge clk_i);
    #DRIVE_DLY;
    r_ready_i = 1'b0;
  endtask

  initial begin
    int    rand_init;
    int    errs_before;
    int    n_wr;
    int    n_rd;
    int    n_err;
    resp_t resp;
    data_t rdata;
    rst_n_i     = 1'b0;
    aw_addr_i   = '0;
    aw_valid_i  = 1'b0;
    w_data_i    = '0;
    w_strb_i    = '0;
    w_valid_i   = 1'b0;
    b_ready_i   = 1'b0;
    ar_addr_i   = '0;
    ar_valid_i  = 1'b0;
    r_ready_i   = 1'b0;
    error_count = 0;
    test_count  = 0;
    test_fail   = 0;
    timed_out   = 1'b0;
    rand_init   = $urandom(32'h2a75);
    build_table();

    repeat (5) @(posedge clk_i);
    #DRIVE_DLY;
    rst_n_i = 1'b1;

    // Idle state straight after reset
    @(negedge clk_i);
    errs_before = error_count;
    check_flag("after_reset", 1'b0, b_valid_o);
    check_flag("after_reset", 1'b0, r_valid_o);
    check_count("after_reset", '0, wr_count_o);
    check_count("after_reset", '0, rd_count_o);
    check_count("after_reset", '0, err_count_o);
    close_test("after_reset", errs_before);
    @(posedge clk_i);
    #DRIVE_DLY;

    n_wr  = 0;
    n_rd  = 0;
    n_err = 0;
    for (int i = 0; i < tbl_len; i++) begin
      errs_before = error_count;
      if (tbl_is_wr[i]) begin
        n_wr++;
        run_write(i, resp);
      end else begin
        n_rd++;
        run_read(i, rdata, resp);
        if (!timed_out) check_data(tbl_name[i], tbl_exp_data[i], rdata);
      end
      if (tbl_exp_resp[i] != RESP_OKAY) n_err++;
      if (!timed_out) check_resp(tbl_name[i], tbl_exp_resp[i], resp);
      close_test(tbl_name[i], errs_before);
      if (timed_out) break;
    end

    @(negedge clk_i);
    errs_before = error_count;
    check_count("wr_count", n_wr, wr_count_o);
    check_count("rd_count", n_rd, rd_count_o);
    check_count("err_count", n_err, err_count_o);
    close_test("counters", errs_before);

    $display("Tests run %0d, passed %0d, failed %0d, errors %0d",
             test_count, test_count - test_fail, test_fail, error_count);
    if (error_count == 0 && !timed_out) begin
      $display("Simulation completed successfully");
    end else begin
      $display("Simulation failed");
    end
    $finish;
  end

endmodule
